// ==== design/core_bus_macros.svh ====
/*
 * core bus bridge widths.
 * address, data and byte-select widths shared by the package,
 * the aligners and the arbiter, plus the testbench timeout step.
 */
`ifndef CORE_BUS_MACROS_SVH
`define CORE_BUS_MACROS_SVH

`default_nettype none

// byte address, word data.
`define CB_ADDR_W 32
`define CB_DATA_W 32

// one select bit per data byte.
`define CB_SEL_W 4

// cycles allowed per stimulus entry before the run is stopped.
`define CB_TIMEOUT_DIV 16

`default_nettype wire

`endif

// ==== design/core_bus_pkg.sv ====
/*
 * core bus package.
 * request and response structs for the fetch port, the load/store
 * port and the shared Wishbone classic bus, and the access-size enum.
 */
`include "core_bus_macros.svh"

`default_nettype none

package core_bus_pkg;

	// load/store access size, as the core encodes it.
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} access_size_e;

	typedef struct packed {
		logic [`CB_ADDR_W-1:0] addr;   // halfword aligned.
		logic                  valid;
	} ireq_t;

	typedef struct packed {
		logic [`CB_DATA_W-1:0] instr;  // compressed ones come zero-extended.
		logic                  ready;
	} irsp_t;

	typedef struct packed {
		logic [`CB_ADDR_W-1:0] addr;
		logic [`CB_DATA_W-1:0] wdata;  // right aligned, as the core holds it.
		access_size_e          size;
		logic                  is_unsigned;  // loads only.
		logic                  write;
		logic                  valid;
	} dreq_t;

	typedef struct packed {
		logic [`CB_DATA_W-1:0] rdata;  // already extended.
		logic                  ready;
	} drsp_t;

	// classic single transfer bus, initiator side.
	typedef struct packed {
		logic [`CB_ADDR_W-1:0] adr;
		logic [`CB_DATA_W-1:0] dat_w;
		logic [`CB_SEL_W-1:0]  sel;
		logic                  we;
		logic                  cyc;
		logic                  stb;
	} wb_req_t;

	typedef struct packed {
		logic [`CB_DATA_W-1:0] dat_r;
		logic                  ack;
	} wb_rsp_t;

endpackage

`default_nettype wire

// ==== design/fetch_aligner.sv ====
/*
 * fetch aligner.
 * turns a halfword aligned instruction fetch into one or two word
 * reads on the bus. a 32-bit instruction that starts in the upper
 * half of a word is joined with the lower half of the next word.
 */
`include "core_bus_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module fetch_aligner import core_bus_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  ireq_t   ireq,
	output irsp_t   irsp,
	output wb_req_t fetch_bus,
	input  wb_rsp_t fetch_rsp
);

	typedef enum logic {
		F_FIRST,
		F_SECOND
	} fetch_state_e;

	fetch_state_e state;
	logic [15:0] kept_half;  // upper half of the first word.
	logic odd_half;
	logic spans;
	logic [`CB_ADDR_W-3:0] word_idx;

	assign odd_half = ireq.addr[1];  // fetch starts at the upper half.

	// low bits 2'b11 mark a full size instruction.
	assign spans = odd_half && (fetch_rsp.dat_r[17:16] == 2'b11);

	// second read goes to the next word.
	assign word_idx = ireq.addr[`CB_ADDR_W-1:2] + (`CB_ADDR_W-2)'(state == F_SECOND);

	always_comb begin
		fetch_bus = '0;
		fetch_bus.adr = {word_idx, 2'b00};
		fetch_bus.sel = '1;  // always a full word read.
		fetch_bus.we = 1'b0;
		fetch_bus.cyc = ireq.valid || (state == F_SECOND);
		fetch_bus.stb = ireq.valid || (state == F_SECOND);
	end

	always_comb begin
		irsp.ready = 1'b0;
		irsp.instr = fetch_rsp.dat_r;  // aligned fetch, whole word.
		if (state == F_SECOND) begin
			irsp.ready = fetch_rsp.ack;
			irsp.instr = {fetch_rsp.dat_r[15:0], kept_half};
		end else if (odd_half) begin
			// only done here when the upper half is compressed.
			irsp.ready = fetch_rsp.ack && !spans;
			irsp.instr = {16'h0000, fetch_rsp.dat_r[31:16]};
		end else begin
			irsp.ready = fetch_rsp.ack;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= F_FIRST;
		end else if (fetch_rsp.ack) begin
			if (state == F_FIRST && spans) begin
				state <= F_SECOND;  // next word read starts next cycle.
			end else begin
				state <= F_FIRST;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == F_FIRST && fetch_rsp.ack && spans) begin
			kept_half <= fetch_rsp.dat_r[31:16];
		end
	end

endmodule

`default_nettype wire

// ==== design/lsu_aligner.sv ====
/*
 * load/store aligner.
 * maps a byte, halfword or word access onto one word transfer,
 * with byte selects and replicated store data on the way out and
 * lane extraction with sign or zero extension on the way back.
 */
`include "core_bus_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module lsu_aligner import core_bus_pkg::*; (
	input  dreq_t   dreq,
	output drsp_t   drsp,
	output wb_req_t data_bus,
	input  wb_rsp_t data_rsp
);

	logic [1:0] offset;
	logic [`CB_SEL_W-1:0] lane_sel;
	logic [`CB_DATA_W-1:0] lane_wdata;
	logic [`CB_DATA_W-1:0] lane_rdata;

	assign offset = dreq.addr[1:0];

	// selects and store data per size.
	always_comb begin
		case (dreq.size)
			SIZE_BYTE: begin
				lane_sel = `CB_SEL_W'(1) << offset;
				lane_wdata = {4{dreq.wdata[7:0]}};
			end
			SIZE_HALF: begin
				lane_sel = offset[1] ? 4'b1100 : 4'b0011;
				lane_wdata = {2{dreq.wdata[15:0]}};
			end
			default: begin
				lane_sel = '1;
				lane_wdata = dreq.wdata;
			end
		endcase
	end

	always_comb begin
		data_bus.adr = {dreq.addr[`CB_ADDR_W-1:2], 2'b00};  // word aligned.
		data_bus.dat_w = lane_wdata;
		data_bus.sel = lane_sel;
		data_bus.we = dreq.write;
		data_bus.cyc = dreq.valid;
		data_bus.stb = dreq.valid;
	end

	// addressed lanes moved down to bit 0.
	assign lane_rdata = data_rsp.dat_r >> {offset, 3'b000};

	always_comb begin
		case (dreq.size)
			SIZE_BYTE: begin
				if (dreq.is_unsigned) begin
					drsp.rdata = {24'h000000, lane_rdata[7:0]};
				end else begin
					drsp.rdata = {{24{lane_rdata[7]}}, lane_rdata[7:0]};
				end
			end
			SIZE_HALF: begin
				if (dreq.is_unsigned) begin
					drsp.rdata = {16'h0000, lane_rdata[15:0]};
				end else begin
					drsp.rdata = {{16{lane_rdata[15]}}, lane_rdata[15:0]};
				end
			end
			default: drsp.rdata = data_rsp.dat_r;
		endcase
		drsp.ready = data_rsp.ack;  // no added cycles.
	end

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
/*
 * bus arbiter.
 * shares the single bus initiator between the data and fetch sides.
 * data wins in idle; the grant holds until ack.
 */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter import core_bus_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  wb_req_t fetch_bus,
	input  wb_req_t data_bus,
	output wb_rsp_t fetch_rsp,
	output wb_rsp_t data_rsp,
	output wb_req_t wb_req,
	input  wb_rsp_t wb_rsp
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_DATA,
		ARB_FETCH
	} arb_state_e;

	arb_state_e state;
	logic data_sel;
	logic fetch_sel;

	// grant is combinational in idle, so stb goes out the same cycle.
	assign data_sel = (state == ARB_DATA) || (state == ARB_IDLE && data_bus.cyc);
	assign fetch_sel = (state == ARB_FETCH) ||
		(state == ARB_IDLE && !data_bus.cyc && fetch_bus.cyc);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= ARB_IDLE;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (data_bus.cyc && !wb_rsp.ack) begin
						state <= ARB_DATA;  // data has priority.
					end else if (fetch_bus.cyc && !wb_rsp.ack) begin
						state <= ARB_FETCH;
					end
				end
				ARB_DATA, ARB_FETCH: begin
					if (wb_rsp.ack) begin
						state <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	always_comb begin
		if (data_sel) begin
			wb_req = data_bus;
		end else if (fetch_sel) begin
			wb_req = fetch_bus;
		end else begin
			wb_req = '0;  // bus idle.
		end
	end

	assign data_rsp.dat_r = wb_rsp.dat_r;
	assign fetch_rsp.dat_r = wb_rsp.dat_r;
	assign data_rsp.ack = data_sel && wb_rsp.ack;  // ack only to the owner.
	assign fetch_rsp.ack = fetch_sel && wb_rsp.ack;

endmodule

`default_nettype wire

// ==== design/core_bus_bridge.sv ====
/*
 * core bus bridge top.
 * joins the fetch aligner and the load/store aligner onto one
 * Wishbone classic initiator through the bus arbiter.
 */
`timescale 1ns/10ps
`default_nettype none

module core_bus_bridge import core_bus_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  ireq_t   ireq,
	output irsp_t   irsp,
	input  dreq_t   dreq,
	output drsp_t   drsp,
	output wb_req_t wb_req,
	input  wb_rsp_t wb_rsp
);

	wb_req_t fetch_bus;
	wb_rsp_t fetch_rsp;
	wb_req_t data_bus;
	wb_rsp_t data_rsp;

	fetch_aligner i_fetch_aligner (
		.clock     (clock),
		.reset     (reset),
		.ireq      (ireq),
		.irsp      (irsp),
		.fetch_bus (fetch_bus),
		.fetch_rsp (fetch_rsp)
	);

	// purely combinational side.
	lsu_aligner i_lsu_aligner (
		.dreq     (dreq),
		.drsp     (drsp),
		.data_bus (data_bus),
		.data_rsp (data_rsp)
	);

	bus_arbiter i_bus_arbiter (
		.clock     (clock),
		.reset     (reset),
		.fetch_bus (fetch_bus),
		.data_bus  (data_bus),
		.fetch_rsp (fetch_rsp),
		.data_rsp  (data_rsp),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp)
	);

endmodule

`default_nettype wire

// ==== dv/wb_mem_model.sv ====
/*
 * bus memory model.
 * classic single transfer responder with a settable ack delay of
 * 0 to 3 cycles. each word is preloaded with its word address times
 * a fill constant, and stores honour the byte selects.
 */
`include "core_bus_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module wb_mem_model import core_bus_pkg::*; #(
	parameter logic [31:0] fill_mult = 32'h0003_0001
) (
	input  logic       clock,
	input  logic       reset,
	input  logic [1:0] ack_delay,
	input  wb_req_t    wb_req,
	output wb_rsp_t    wb_rsp
);

	logic [`CB_DATA_W-1:0] mem [0:255];
	logic busy;
	logic [1:0] wait_cnt;
	logic [7:0] idx;

	assign idx = wb_req.adr[9:2];  // 256 words modeled.

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'(i) * fill_mult;
		end
	end

	task automatic finish_transfer();
		wb_rsp.ack <= 1'b1;
		wb_rsp.dat_r <= mem[idx];
		if (wb_req.we) begin
			for (int k = 0; k < `CB_SEL_W; k++) begin
				if (wb_req.sel[k]) mem[idx][8*k +: 8] <= wb_req.dat_w[8*k +: 8];
			end
		end
	endtask

	always @(posedge clock or posedge reset) begin
		if (reset) begin
			wb_rsp <= '0;
			busy <= 1'b0;
			wait_cnt <= '0;
		end else begin
			wb_rsp.ack <= 1'b0;  // one cycle pulse.
			if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
				if (!busy) begin
					if (ack_delay == 2'd0) begin
						finish_transfer();
					end else begin
						busy <= 1'b1;
						wait_cnt <= ack_delay;
					end
				end else if (wait_cnt == 2'd1) begin
					busy <= 1'b0;
					finish_transfer();
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/core_bus_bridge_chk.sv ====
/*
 * bus protocol checks.
 * bound into the bus arbiter. watches the shared bus request and
 * the acks routed back to the fetch and data sides.
 */
`timescale 1ns/10ps
`default_nettype none

module core_bus_bridge_chk import core_bus_pkg::*; (
	input logic    clock,
	input logic    reset,
	input wb_req_t wb_req,
	input wb_rsp_t wb_rsp,
	input wb_rsp_t fetch_rsp,
	input wb_rsp_t data_rsp
);

	// strobe only inside a cycle.
	a_stb_in_cyc: assert property (@(posedge clock) disable iff (reset)
		wb_req.stb |-> wb_req.cyc)
		else $error("stb high without cyc");

	// initiator holds the whole request until ack.
	a_req_held: assert property (@(posedge clock) disable iff (reset)
		(wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req))
		else $error("bus request changed before ack");

	// every bus ack goes back to exactly one side.
	a_ack_one_side: assert property (@(posedge clock) disable iff (reset)
		wb_rsp.ack |-> (fetch_rsp.ack ^ data_rsp.ack))
		else $error("bus ack not routed to exactly one side");

endmodule

bind bus_arbiter core_bus_bridge_chk i_chk (
	.clock     (clock),
	.reset     (reset),
	.wb_req    (wb_req),
	.wb_rsp    (wb_rsp),
	.fetch_rsp (fetch_rsp),
	.data_rsp  (data_rsp)
);

`default_nettype wire

// ==== dv/tb_core_bus_bridge.sv ====
/*
 * core bus bridge testbench.
 * applies a table of fetches, loads and stores against a preloaded
 * bus memory, with random ack delay, and checks instruction assembly,
 * lane steering, load extension and data priority.
 */
`include "core_bus_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module tb_core_bus_bridge import core_bus_pkg::*; ();

	typedef enum logic [1:0] {
		K_FETCH,
		K_LOAD,
		K_STORE,
		K_PAIR  // load at addr and fetch at wdata, same cycle.
	} kind_e;

	typedef struct packed {
		kind_e        kind;
		logic [31:0]  addr;
		access_size_e size;
		logic         is_unsigned;
		logic [31:0]  wdata;
		logic [31:0]  exp_val;
	} entry_t;

	localparam logic [31:0] fill_mult = 32'h0003_0001;

	logic clock;
	logic reset;
	logic [1:0] ack_delay;
	ireq_t ireq;
	irsp_t irsp;
	dreq_t dreq;
	drsp_t drsp;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	entry_t table_q[$];
	logic [31:0] shadow [0:255];  // expected memory contents.
	int cycles = 0;
	int cycle_limit = 0;
	int errors = 0;

	core_bus_bridge i_dut (
		.clock  (clock),
		.reset  (reset),
		.ireq   (ireq),
		.irsp   (irsp),
		.dreq   (dreq),
		.drsp   (drsp),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	wb_mem_model #(.fill_mult(fill_mult)) i_mem (
		.clock     (clock),
		.reset     (reset),
		.ack_delay (ack_delay),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: no ready seen within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	function automatic logic [31:0] fetch_ref(logic [31:0] addr);
		logic [31:0] w0;
		logic [15:0] hi;
		w0 = shadow[addr[9:2]];
		hi = w0[31:16];
		if (!addr[1]) return w0;
		if (hi[1:0] != 2'b11) return {16'h0000, hi};  // compressed.
		return {shadow[addr[9:2] + 8'd1][15:0], hi};
	endfunction

	function automatic int fetch_reads(logic [31:0] addr);
		logic [31:0] w0;
		w0 = shadow[addr[9:2]];
		return (addr[1] && w0[17:16] == 2'b11) ? 2 : 1;
	endfunction

	function automatic logic [3:0] lane_sel_ref(logic [31:0] addr, access_size_e size);
		logic [3:0] sel;
		int nbytes;
		int off;
		nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
		off = (size == SIZE_WORD) ? 0 : int'(addr[1:0]);
		for (int k = 0; k < 4; k++) sel[k] = (k >= off) && (k < off + nbytes);
		return sel;
	endfunction

	function automatic logic [7:0] store_byte(access_size_e size, logic [31:0] wdata, int k);
		if (size == SIZE_BYTE) return wdata[7:0];
		if (size == SIZE_HALF) return wdata[8*(k%2) +: 8];
		return wdata[8*k +: 8];
	endfunction

	function automatic logic [31:0] load_ref(logic [31:0] addr, access_size_e size,
		logic is_unsigned);
		logic [31:0] shifted;
		shifted = shadow[addr[9:2]] >> (8 * addr[1:0]);
		if (size == SIZE_BYTE) begin
			return is_unsigned ? {24'h0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
		end
		if (size == SIZE_HALF) begin
			return is_unsigned ? {16'h0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
		end
		return shadow[addr[9:2]];
	endfunction

	function automatic void store_shadow(logic [31:0] addr, access_size_e size,
		logic [31:0] wdata);
		logic [3:0] sel;
		sel = lane_sel_ref(addr, size);
		for (int k = 0; k < 4; k++) begin
			if (sel[k]) shadow[addr[9:2]][8*k +: 8] = store_byte(size, wdata, k);
		end
	endfunction

	task automatic report_value(string name, logic [31:0] exp_v, logic [31:0] got);
		errors++;
		$display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, got);
		$display("TB FAILED");
		$fatal(1, "value mismatch");
	endtask

	// expected result follows the shadow memory as built so far.
	task automatic add_entry(kind_e kind, logic [31:0] addr, access_size_e size,
		logic is_unsigned, logic [31:0] wdata);
		entry_t e;
		e = '{kind, addr, size, is_unsigned, wdata, 32'h0};
		case (kind)
			K_FETCH: e.exp_val = fetch_ref(addr);
			K_STORE: store_shadow(addr, size, wdata);
			default: e.exp_val = load_ref(addr, size, is_unsigned);
		endcase
		table_q.push_back(e);
	endtask

	task automatic run_fetch(entry_t e);
		int reads;
		logic [31:0] exp_adr;
		reads = 0;
		ireq.addr = e.addr;
		ireq.valid = 1'b1;
		do begin
			@(negedge clock);
			if (wb_rsp.ack) begin
				reads++;
				// a second read goes to the following word.
				exp_adr = {e.addr[31:2] + 30'(reads - 1), 2'b00};
				assert (wb_req.stb) else report_value("wb_req.stb", 1, wb_req.stb);
				assert (!wb_req.we) else report_value("wb_req.we", 0, wb_req.we);
				assert (wb_req.adr == exp_adr)
					else report_value("wb_req.adr", exp_adr, wb_req.adr);
			end
		end while (!irsp.ready);
		assert (irsp.instr == e.exp_val) else report_value("irsp.instr", e.exp_val, irsp.instr);
		assert (reads == fetch_reads(e.addr))
			else report_value("bus reads", fetch_reads(e.addr), reads);
		@(posedge clock);
		@(negedge clock);
		ireq = '0;
	endtask

	task automatic run_data(entry_t e);
		logic [3:0] sel;
		logic [7:0] lane;
		logic [31:0] exp_adr;
		sel = lane_sel_ref(e.addr, e.size);
		exp_adr = {e.addr[31:2], 2'b00};  // word aligned on the bus.
		dreq = '{e.addr, e.wdata, e.size, e.is_unsigned, e.kind == K_STORE, 1'b1};
		do @(negedge clock); while (!drsp.ready);
		assert (wb_req.adr == exp_adr) else report_value("wb_req.adr", exp_adr, wb_req.adr);
		assert (wb_req.we == (e.kind == K_STORE))
			else report_value("wb_req.we", e.kind == K_STORE, wb_req.we);
		if (e.kind == K_STORE) begin
			assert (wb_req.sel == sel) else report_value("wb_req.sel", sel, wb_req.sel);
			for (int k = 0; k < 4; k++) begin
				lane = store_byte(e.size, e.wdata, k);
				if (sel[k]) begin
					assert (wb_req.dat_w[8*k +: 8] == lane)
						else report_value("wb_req.dat_w lane", lane, wb_req.dat_w[8*k +: 8]);
				end
			end
		end else begin
			assert (drsp.rdata == e.exp_val) else report_value("drsp.rdata", e.exp_val, drsp.rdata);
		end
		@(posedge clock);
		@(negedge clock);
		dreq = '0;
	endtask

	task automatic run_pair(entry_t e);
		int n;
		int d_at;
		int i_at;
		logic [31:0] i_exp;
		n = 0;
		d_at = -1;
		i_at = -1;
		i_exp = fetch_ref(e.wdata);
		ireq = '{e.wdata, 1'b1};
		dreq = '{e.addr, 32'h0, e.size, e.is_unsigned, 1'b0, 1'b1};
		while (d_at < 0 || i_at < 0) begin
			@(negedge clock);
			n++;
			if (d_at >= 0) dreq = '0;
			if (dreq.valid && drsp.ready && d_at < 0) begin
				assert (drsp.rdata == e.exp_val)
					else report_value("drsp.rdata", e.exp_val, drsp.rdata);
				d_at = n;
			end
			if (irsp.ready && i_at < 0) begin
				assert (irsp.instr == i_exp) else report_value("irsp.instr", i_exp, irsp.instr);
				i_at = n;
			end
		end
		assert (d_at < i_at) else begin
			errors++;
			$display("data ready did not come before fetch ready");
			$display("TB FAILED");
			$fatal(1, "priority order wrong");
		end
		@(posedge clock);
		@(negedge clock);
		ireq = '0;
		dreq = '0;
	endtask

	initial begin
		void'($urandom(32'h3f7a));
		reset = 1'b1;
		ack_delay = 2'd0;
		ireq = '0;
		dreq = '0;
		for (int i = 0; i < 256; i++) shadow[i] = 32'(i) * fill_mult;

		add_entry(K_FETCH, 32'h10, SIZE_WORD, 1'b0, 32'h0);  // aligned.
		add_entry(K_FETCH, 32'h0a, SIZE_WORD, 1'b0, 32'h0);  // compressed upper half.
		add_entry(K_FETCH, 32'h06, SIZE_WORD, 1'b0, 32'h0);  // spans two words.
		add_entry(K_FETCH, 32'h0e, SIZE_WORD, 1'b0, 32'h0);
		add_entry(K_FETCH, 32'h16, SIZE_WORD, 1'b0, 32'h0);
		add_entry(K_STORE, 32'h20, SIZE_BYTE, 1'b0, 32'h0000_0081);
		add_entry(K_STORE, 32'h21, SIZE_BYTE, 1'b0, 32'h0000_007f);
		add_entry(K_STORE, 32'h22, SIZE_BYTE, 1'b0, 32'hffff_ffc3);
		add_entry(K_STORE, 32'h23, SIZE_BYTE, 1'b0, 32'h0000_0005);
		add_entry(K_LOAD, 32'h20, SIZE_WORD, 1'b0, 32'h0);
		add_entry(K_STORE, 32'h29, SIZE_BYTE, 1'b0, 32'h0000_005a);
		add_entry(K_LOAD, 32'h28, SIZE_WORD, 1'b0, 32'h0);  // other bytes untouched.
		add_entry(K_STORE, 32'h24, SIZE_HALF, 1'b0, 32'h0000_8001);
		add_entry(K_STORE, 32'h26, SIZE_HALF, 1'b0, 32'h0000_1234);
		add_entry(K_LOAD, 32'h24, SIZE_WORD, 1'b0, 32'h0);
		add_entry(K_STORE, 32'h32, SIZE_HALF, 1'b0, 32'h0000_f00d);
		add_entry(K_LOAD, 32'h30, SIZE_WORD, 1'b0, 32'h0);
		add_entry(K_LOAD, 32'h20, SIZE_BYTE, 1'b0, 32'h0);
		add_entry(K_LOAD, 32'h20, SIZE_BYTE, 1'b1, 32'h0);
		add_entry(K_LOAD, 32'h21, SIZE_BYTE, 1'b0, 32'h0);
		add_entry(K_LOAD, 32'h22, SIZE_BYTE, 1'b0, 32'h0);
		add_entry(K_LOAD, 32'h22, SIZE_BYTE, 1'b1, 32'h0);
		add_entry(K_LOAD, 32'h23, SIZE_BYTE, 1'b1, 32'h0);
		add_entry(K_LOAD, 32'h24, SIZE_HALF, 1'b0, 32'h0);
		add_entry(K_LOAD, 32'h24, SIZE_HALF, 1'b1, 32'h0);
		add_entry(K_LOAD, 32'h26, SIZE_HALF, 1'b0, 32'h0);
		add_entry(K_STORE, 32'h2c, SIZE_WORD, 1'b0, 32'hdead_beef);
		add_entry(K_LOAD, 32'h2c, SIZE_WORD, 1'b0, 32'h0);
		add_entry(K_PAIR, 32'h24, SIZE_HALF, 1'b0, 32'h0000_0016);
		cycle_limit = table_q.size() * `CB_TIMEOUT_DIV + 4;  // plus reset.

		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		foreach (table_q[i]) begin
			ack_delay = 2'($urandom_range(3, 0));
			case (table_q[i].kind)
				K_FETCH: run_fetch(table_q[i]);
				K_PAIR: run_pair(table_q[i]);
				default: run_data(table_q[i]);
			endcase
		end

		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/core_bus_pkg.sv
design/fetch_aligner.sv
design/lsu_aligner.sv
design/bus_arbiter.sv
design/core_bus_bridge.sv
dv/wb_mem_model.sv
dv/core_bus_bridge_chk.sv
dv/tb_core_bus_bridge.sv

// ==== Bender.yml ====
package:
  name: core_bus_bridge

sources:
  - include_dirs:
      - design
    files:
      - design/core_bus_pkg.sv
      - design/fetch_aligner.sv
      - design/lsu_aligner.sv
      - design/bus_arbiter.sv
      - design/core_bus_bridge.sv
  - target: dv
    include_dirs:
      - design
    files:
      - dv/wb_mem_model.sv
      - dv/core_bus_bridge_chk.sv
      - dv/tb_core_bus_bridge.sv
